// File: rtl/fpAdder_consts.svh
// Single-precision format constants, included by the adder packages and RTL modules
`ifndef FPADDER_CONSTS_SVH
`define FPADDER_CONSTS_SVH

// Field widths of the IEEE-754 single-precision word
`define FP_EXP_WIDTH 8
`define FP_MAN_WIDTH 23

// Aligned mantissa is the hidden bit, the stored fraction and the guard field
`define FP_GUARD_BITS 8
`define FP_ALIGN_WIDTH 32

// Exponent encodings
`define FP_EXP_BIAS 127
`define FP_EXP_MAX 255

// Every NaN result is this quiet NaN
`define FP_QNAN 32'h7fc00000

`endif

// File: rtl/fpFormatPkg.sv
// Types for the single-precision number format and operand classes, imported by the adder RTL
`include "fpAdder_consts.svh"

package fpFormatPkg;

    // One packed IEEE-754 word, sign in the top bit
    typedef logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH:0] fpWord;

    typedef logic [`FP_EXP_WIDTH-1:0] fpExponent;

    typedef logic [`FP_MAN_WIDTH-1:0] fpMantissa;

    // Hidden bit, stored fraction, then guard bits
    typedef logic [`FP_ALIGN_WIDTH-1:0] fpAligned;

    typedef enum logic [2:0]
    {
        clsZero,
        clsSubnormal,
        clsNormal,
        clsInf,
        clsNaN
    } fpClass;

endpackage

// File: rtl/fpOpsPkg.sv
// Types for the requested operation and the special-result kinds of the adder

package fpOpsPkg;

    typedef enum logic
    {
        opAdd,
        opSub
    } fpOp;

    // Which result replaces the arithmetic path
    typedef enum logic [2:0]
    {
        spNone,
        spNaN,
        spInf,
        spPassA,
        spPassB,
        spZero
    } fpSpecial;

endpackage

// File: rtl/fpUnpack.sv
// Combinational field split and operand classification feeding both stage-one blocks
`timescale 1ns/1ps
`include "fpAdder_consts.svh"

module fpUnpack
    import fpFormatPkg::*, fpOpsPkg::*;
(
    input  fpWord     operandA,
    input  fpWord     operandB,
    input  fpOp       op,
    output logic      signA,
    output logic      signB,
    output fpExponent exponentA,
    output fpExponent exponentB,
    output fpMantissa mantissaA,
    output fpMantissa mantissaB,
    output fpClass    classA,
    output fpClass    classB
);

    localparam int signBit = `FP_EXP_WIDTH + `FP_MAN_WIDTH;
    localparam int expLow  = `FP_MAN_WIDTH;

    function automatic fpClass classify(input fpExponent exponent, input fpMantissa mantissa);
        fpClass cls;
        if (exponent == '0)
            cls = (mantissa == '0) ? clsZero : clsSubnormal;
        else if (exponent == `FP_EXP_WIDTH'(`FP_EXP_MAX))
            cls = (mantissa == '0) ? clsInf : clsNaN;
        else
            cls = clsNormal;
        return cls;
    endfunction

    assign exponentA = operandA[signBit-1:expLow];
    assign exponentB = operandB[signBit-1:expLow];
    assign mantissaA = operandA[expLow-1:0];
    assign mantissaB = operandB[expLow-1:0];

    // Subtraction is an addition with B negated, so later stages only see signed addends
    assign signA = operandA[signBit];
    assign signB = operandB[signBit] ^ (op == opSub);

    assign classA = classify(exponentA, mantissaA);
    assign classB = classify(exponentB, mantissaB);

endmodule

// File: rtl/mantissaAlign.sv
// Stage one of the adder: exponent compare and mantissa alignment with sticky, registered
`timescale 1ns/1ps
`include "fpAdder_consts.svh"

module mantissaAlign
    import fpFormatPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      inValid,
    input  fpExponent exponentA,
    input  fpExponent exponentB,
    input  fpMantissa mantissaA,
    input  fpMantissa mantissaB,
    input  fpClass    classA,
    input  fpClass    classB,
    output logic      alignValid,
    output fpAligned  alignedMantissaA,
    output fpAligned  alignedMantissaB,
    output fpExponent exponentOut,
    output logic      aFirst,
    output logic      sticky,
    output logic      shiftOverflow
);

    logic      hiddenA;
    logic      hiddenB;
    fpExponent effExpA;
    fpExponent effExpB;
    fpExponent expDiff;
    fpAligned  fullA;
    fpAligned  fullB;
    fpAligned  smallFull;
    fpAligned  smallShifted;
    fpAligned  lostMask;
    logic      aFirstNext;
    logic      stickyNext;
    logic      overflowNext;

    // ####################################################################
    // Exponent compare
    // ####################################################################

    // Subnormals and zeros carry no hidden bit and sit at exponent one
    assign hiddenA = (classA == clsNormal);
    assign hiddenB = (classB == clsNormal);
    assign effExpA = hiddenA ? exponentA : fpExponent'(1);
    assign effExpB = hiddenB ? exponentB : fpExponent'(1);

    assign fullA = {hiddenA, mantissaA, {`FP_GUARD_BITS{1'b0}}};
    assign fullB = {hiddenB, mantissaB, {`FP_GUARD_BITS{1'b0}}};

    // Ties go to A so an exact cancellation subtracts in a fixed order
    assign aFirstNext = {effExpA, fullA} >= {effExpB, fullB};
    assign expDiff    = aFirstNext ? effExpA - effExpB : effExpB - effExpA;

    // ####################################################################
    // Mantissa alignment
    // ####################################################################

    assign smallFull    = aFirstNext ? fullB : fullA;
    assign smallShifted = smallFull >> expDiff;

    // The whole smaller mantissa has left the field
    assign overflowNext = (expDiff >= `FP_ALIGN_WIDTH);

    assign lostMask   = overflowNext ? '1 : (fpAligned'(1) << expDiff) - fpAligned'(1);
    assign stickyNext = |(smallFull & lostMask);

    always_ff @(posedge clk)
    begin
        if (rst)
            alignValid <= 1'b0;
        else
            alignValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            alignedMantissaA <= aFirstNext ? fullA : smallShifted;
            alignedMantissaB <= aFirstNext ? smallShifted : fullB;
            exponentOut      <= aFirstNext ? effExpA : effExpB;
            aFirst           <= aFirstNext;
            sticky           <= stickyNext;
            shiftOverflow    <= overflowNext;
        end
    end

    // Equal input exponents never lose bits off the end of the field
    assert property (@(posedge clk) disable iff (rst)
        inValid && (exponentA == exponentB) |=> !shiftOverflow);

    assert property (@(posedge clk) rst |=> !alignValid);

endmodule

// File: rtl/specialCase.sv
// Stage one of the adder: NaN, infinity and zero handling that decides the bypass, registered
`timescale 1ns/1ps
`include "fpAdder_consts.svh"

module specialCase
    import fpFormatPkg::*, fpOpsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  logic     signA,
    input  logic     signB,
    input  fpClass   classA,
    input  fpClass   classB,
    input  fpWord    operandA,
    input  fpWord    operandB,
    output logic     bypass,
    output fpSpecial special,
    output logic     signAOut,
    output logic     signBOut,
    output fpWord    passValue
);

    localparam int magTop = `FP_EXP_WIDTH + `FP_MAN_WIDTH - 1;

    fpSpecial specialNext;
    fpWord    passNext;
    logic     bypassNext;
    logic     aNaN, bNaN, aInf, bInf, aZero, bZero;

    assign aNaN  = (classA == clsNaN);
    assign bNaN  = (classB == clsNaN);
    assign aInf  = (classA == clsInf);
    assign bInf  = (classB == clsInf);
    assign aZero = (classA == clsZero);
    assign bZero = (classB == clsZero);

    // Any operand outside the finite nonzero range skips the arithmetic path
    assign bypassNext = aNaN | bNaN | aInf | bInf | aZero | bZero;

    always_comb
    begin
        specialNext = spNone;
        passNext    = {signA, operandA[magTop:0]};
        if (aNaN || bNaN || (aInf && bInf && (signA != signB)))
            specialNext = spNaN;
        else if (aInf || bInf)
        begin
            specialNext = spInf;
            passNext    = aInf ? {signA, operandA[magTop:0]} : {signB, operandB[magTop:0]};
        end
        else if (aZero && !bZero)
        begin
            specialNext = spPassB;
            passNext    = {signB, operandB[magTop:0]};
        end
        else if (bZero && !aZero)
            specialNext = spPassA;
        else if (aZero && bZero)
            specialNext = spZero;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bypass  <= 1'b0;
            special <= spNone;
        end
        else if (inValid)
        begin
            bypass  <= bypassNext;
            special <= specialNext;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            signAOut  <= signA;
            signBOut  <= signB;
            passValue <= passNext;
        end
    end

    // The class test and the priority chain must agree on when to bypass
    assert property (@(posedge clk) disable iff (rst) bypass == (special != spNone));

endmodule

// File: rtl/addNormalize.sv
// Stage two of the adder: mantissa add or subtract, normalize, round and final result select
`timescale 1ns/1ps
`include "fpAdder_consts.svh"

module addNormalize
    import fpFormatPkg::*, fpOpsPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      alignValid,
    input  fpAligned  alignedMantissaA,
    input  fpAligned  alignedMantissaB,
    input  fpExponent exponentOut,
    input  logic      aFirst,
    input  logic      sticky,
    input  logic      bypass,
    input  fpSpecial  special,
    input  logic      signAOut,
    input  logic      signBOut,
    input  fpWord     passValue,
    output logic      outValid,
    output fpWord     result
);

    // Carry bit, aligned mantissa, then one bit holding the sticky
    localparam int sumWidth = `FP_ALIGN_WIDTH + 2;
    localparam int topBit   = sumWidth - 2;
    localparam int keepLow  = topBit - `FP_MAN_WIDTH;
    localparam int guardBit = keepLow - 1;

    logic [sumWidth-1:0]    largeExt;
    logic [sumWidth-1:0]    smallExt;
    logic [sumWidth-1:0]    rawSum;
    logic [sumWidth-1:0]    shifted;
    logic [sumWidth-1:0]    normalized;
    logic [5:0]             lz;
    logic [9:0]             expBase;
    logic [9:0]             expNorm;
    logic [9:0]             expFinal;
    logic [`FP_MAN_WIDTH+1:0] rounded;
    logic                   sameSign;
    logic                   carry;
    logic                   underflow;
    logic                   roundUp;
    logic                   resultSign;
    fpWord                  arithWord;
    fpWord                  specialWord;
    fpWord                  nextResult;

    function automatic logic [5:0] leadingZeros(input logic [topBit:0] value);
        logic [5:0] count;
        logic       found;
        count = '0;
        found = 1'b0;
        for (int i = topBit; i >= 0; i--)
        begin
            if (value[i])
                found = 1'b1;
            else if (!found)
                count = count + 6'd1;
        end
        return count;
    endfunction

    // ####################################################################
    // Add or subtract, then normalize
    // ####################################################################

    assign sameSign = (signAOut == signBOut);
    assign largeExt = {1'b0, aFirst ? alignedMantissaA : alignedMantissaB, 1'b0};
    // Sticky in the lowest bit borrows correctly on subtraction
    assign smallExt = {1'b0, aFirst ? alignedMantissaB : alignedMantissaA, sticky};
    assign rawSum   = sameSign ? largeExt + smallExt : largeExt - smallExt;

    assign carry   = rawSum[sumWidth-1];
    assign shifted = carry ? {1'b0, rawSum[sumWidth-1:2], rawSum[1] | rawSum[0]} : rawSum;

    assign lz         = leadingZeros(shifted[topBit:0]);
    assign normalized = shifted << lz;

    assign expBase   = {2'b00, exponentOut} + {9'd0, carry};
    assign underflow = ({4'd0, lz} >= expBase);
    assign expNorm   = expBase - {4'd0, lz};

    // ####################################################################
    // Round to nearest even
    // ####################################################################

    assign roundUp = normalized[guardBit]
                   & ((|normalized[guardBit-1:0]) | normalized[keepLow]);
    assign rounded  = {1'b0, normalized[topBit:keepLow]} + {{(`FP_MAN_WIDTH+1){1'b0}}, roundUp};
    // A rounding carry leaves a zero fraction and bumps the exponent
    assign expFinal = expNorm + {9'd0, rounded[`FP_MAN_WIDTH+1]};

    assign resultSign = (sameSign || aFirst) ? signAOut : signBOut;

    always_comb
    begin
        if (rawSum == '0)
            arithWord = '0;
        else if (underflow)
            arithWord = {resultSign, {(`FP_EXP_WIDTH+`FP_MAN_WIDTH){1'b0}}};
        else if (expFinal >= 10'(`FP_EXP_MAX))
            arithWord = {resultSign, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
        else
            arithWord = {resultSign, expFinal[`FP_EXP_WIDTH-1:0], rounded[`FP_MAN_WIDTH-1:0]};
    end

    always_comb
    begin
        case (special)
            spNaN:            specialWord = `FP_QNAN;
            spInf:            specialWord = {passValue[`FP_EXP_WIDTH+`FP_MAN_WIDTH],
                                             {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
            spPassA, spPassB: specialWord = passValue;
            spZero:           specialWord = {signAOut & signBOut,
                                             {(`FP_EXP_WIDTH+`FP_MAN_WIDTH){1'b0}}};
            default:          specialWord = '0;
        endcase
    end

    assign nextResult = bypass ? specialWord : arithWord;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= alignValid;
            if (alignValid)
                result <= nextResult;
        end
    end

    assert property (@(posedge clk) disable iff (rst) 1'b1 |=> (outValid == $past(alignValid)));

endmodule

// File: rtl/fpAdder.sv
// Top level of the two-stage single-precision adder, one operation per cycle, two cycles latency
`timescale 1ns/1ps

module fpAdder
    import fpFormatPkg::*, fpOpsPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  inValid,
    input  fpWord operandA,
    input  fpWord operandB,
    input  fpOp   op,
    output logic  outValid,
    output fpWord result
);

    logic      signA, signB;
    fpExponent exponentA, exponentB;
    fpMantissa mantissaA, mantissaB;
    fpClass    classA, classB;

    logic      alignValid;
    fpAligned  alignedMantissaA, alignedMantissaB;
    fpExponent exponentOut;
    logic      aFirst;
    logic      sticky;

    logic      bypass;
    fpSpecial  special;
    logic      signAOut, signBOut;
    fpWord     passValue;

    fpUnpack unpack (
        .operandA  (operandA),
        .operandB  (operandB),
        .op        (op),
        .signA     (signA),
        .signB     (signB),
        .exponentA (exponentA),
        .exponentB (exponentB),
        .mantissaA (mantissaA),
        .mantissaB (mantissaB),
        .classA    (classA),
        .classB    (classB)
    );

    // Whole-field overflow is already folded into sticky
    mantissaAlign align (
        .clk              (clk),
        .rst              (rst),
        .inValid          (inValid),
        .exponentA        (exponentA),
        .exponentB        (exponentB),
        .mantissaA        (mantissaA),
        .mantissaB        (mantissaB),
        .classA           (classA),
        .classB           (classB),
        .alignValid       (alignValid),
        .alignedMantissaA (alignedMantissaA),
        .alignedMantissaB (alignedMantissaB),
        .exponentOut      (exponentOut),
        .aFirst           (aFirst),
        .sticky           (sticky),
        .shiftOverflow    ()
    );

    specialCase specials (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .signA     (signA),
        .signB     (signB),
        .classA    (classA),
        .classB    (classB),
        .operandA  (operandA),
        .operandB  (operandB),
        .bypass    (bypass),
        .special   (special),
        .signAOut  (signAOut),
        .signBOut  (signBOut),
        .passValue (passValue)
    );

    addNormalize normalize (
        .clk              (clk),
        .rst              (rst),
        .alignValid       (alignValid),
        .alignedMantissaA (alignedMantissaA),
        .alignedMantissaB (alignedMantissaB),
        .exponentOut      (exponentOut),
        .aFirst           (aFirst),
        .sticky           (sticky),
        .bypass           (bypass),
        .special          (special),
        .signAOut         (signAOut),
        .signBOut         (signBOut),
        .passValue        (passValue),
        .outValid         (outValid),
        .result           (result)
    );

endmodule

// File: tb/fpAdderTb.sv
// Table-driven testbench for the two-stage adder, built from the file list with this module as top
`timescale 1ns/1ps

module fpAdderTb
    import fpFormatPkg::*, fpOpsPkg::*;
();

    localparam int    latencyCycles = 2;
    localparam int    drainTimeout  = 20;
    localparam int    randomRounds  = 40;
    localparam fpWord quietNaN      = 32'h7fc00000;

    typedef struct packed
    {
        fpWord operandA;
        fpWord operandB;
        fpOp   op;
        fpWord expected;
    } stimRow;

    // How a returned result is judged
    typedef enum logic [1:0]
    {
        chkExact,
        chkPairFirst,
        chkPairSecond
    } checkKind;

    typedef struct packed
    {
        fpWord    expected;
        checkKind kind;
        int       issueCycle;
    } pendingResult;

    logic  clk;
    logic  rst;
    logic  inValid;
    fpWord operandA;
    fpWord operandB;
    fpOp   op;
    logic  outValid;
    fpWord result;

    stimRow       stimTable[$];
    pendingResult expectQ[$];
    int           cycleCount   = 0;
    int           checkedCount = 0;
    fpWord        pairValue    = '0;
    integer       seed;

    fpAdder i_fpAdder (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .op       (op),
        .outValid (outValid),
        .result   (result)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Each read at a rising edge sees the index of the cycle that just ended
    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    // ####################################################################
    // Checks
    // ####################################################################

    task automatic stopOnError(input string message);
        $display("%s", message);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkWord(input fpWord got, input fpWord expected, input string what);
        if (got !== expected)
            stopOnError($sformatf("** Error at %0t: %s gave %h, expected %h",
                                  $time, what, got, expected));
    endtask

    task automatic checkStrobe(input logic got, input logic expected, input string what);
        if (got !== expected)
            stopOnError($sformatf("** Error at %0t: %s was %b, expected %b",
                                  $time, what, got, expected));
    endtask

    task automatic checkLatency(input int got, input int expected, input string what);
        if (got != expected)
            stopOnError($sformatf("** Error at %0t: %s was %0d cycles, expected %0d",
                                  $time, what, got, expected));
    endtask

    // Every result is matched in order against the operations sent in
    always @(posedge clk)
    begin
        pendingResult head;
        if (!rst && outValid === 1'b1)
        begin
            if (checkedCount >= expectQ.size())
                stopOnError("outValid went high with no operation in flight");
            else
            begin
                head = expectQ[checkedCount];
                case (head.kind)
                    chkExact:     checkWord(result, head.expected, "result");
                    chkPairFirst: pairValue = result;
                    default:      checkWord(result, pairValue, "B+A against A+B");
                endcase
                checkLatency(cycleCount - head.issueCycle, latencyCycles, "outValid latency");
                checkedCount = checkedCount + 1;
            end
        end
    end

    task automatic checkValid(input int timeoutCycles);
        int waited;
        waited = 0;
        while (checkedCount < expectQ.size() && waited < timeoutCycles)
        begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (checkedCount < expectQ.size())
            stopOnError($sformatf("outValid never came for %0d operations after %0d cycles",
                                  expectQ.size() - checkedCount, timeoutCycles));
    endtask

    // ####################################################################
    // Stimulus
    // ####################################################################

    task automatic addRow(input fpWord a, input fpWord b, input fpOp operation,
                          input fpWord expected);
        stimRow row;
        row.operandA = a;
        row.operandB = b;
        row.op       = operation;
        row.expected = expected;
        stimTable.push_back(row);
    endtask

    task automatic loadTable();
        // Normal values, equal and unequal exponents, and gaps lost into sticky
        addRow(32'h3f800000, 32'h3f800000, opAdd, 32'h40000000);
        addRow(32'h3fc00000, 32'h3e800000, opSub, 32'h3fa00000);
        addRow(32'h40000000, 32'h40400000, opAdd, 32'h40a00000);
        addRow(32'h3f800000, 32'h40000000, opSub, 32'hbf800000);
        addRow(32'h3fc00000, 32'h3f800000, opSub, 32'h3f000000);
        addRow(32'h3f800000, 32'h30800000, opAdd, 32'h3f800000);
        addRow(32'h3f800000, 32'h0d800000, opAdd, 32'h3f800000);
        addRow(32'h3f800000, 32'h30800000, opSub, 32'h3f800000);
        addRow(32'h3f800000, 32'h33800001, opAdd, 32'h3f800001);
        addRow(32'h3f800000, 32'h33000001, opSub, 32'h3f7fffff);
        // Ties to even, above the tie and rounding carry into the exponent
        addRow(32'h3f800000, 32'h33800000, opAdd, 32'h3f800000);
        addRow(32'h3f800001, 32'h33800000, opAdd, 32'h3f800002);
        addRow(32'h3f800000, 32'h33c00000, opAdd, 32'h3f800001);
        addRow(32'h3fffffff, 32'h33800000, opAdd, 32'h40000000);
        addRow(32'h3f800000, 32'h3f800001, opAdd, 32'h40000000);
        // NaN, infinity and zero
        addRow(32'h7fc00001, 32'h3f800000, opAdd, quietNaN);
        addRow(32'hffc12345, 32'h00000000, opAdd, quietNaN);
        addRow(32'h7f800000, 32'h7f800000, opSub, quietNaN);
        addRow(32'h7f800000, 32'h7f800000, opAdd, 32'h7f800000);
        addRow(32'hff800000, 32'h40a00000, opAdd, 32'hff800000);
        addRow(32'h3f800000, 32'h7f800000, opSub, 32'hff800000);
        addRow(32'h00000000, 32'h3fc00000, opAdd, 32'h3fc00000);
        addRow(32'h00000000, 32'h3fc00000, opSub, 32'hbfc00000);
        addRow(32'h40490fdb, 32'h00000000, opAdd, 32'h40490fdb);
        addRow(32'h40490fdb, 32'h80000000, opSub, 32'h40490fdb);
        addRow(32'h80000000, 32'h80000000, opAdd, 32'h80000000);
        addRow(32'h00000000, 32'h80000000, opAdd, 32'h00000000);
        addRow(32'h80000000, 32'h00000000, opSub, 32'h80000000);
        addRow(32'h40490fdb, 32'h40490fdb, opSub, 32'h00000000);
        addRow(32'hc0490fdb, 32'h40490fdb, opAdd, 32'h00000000);
        // Subnormal inputs, overflow and flushed underflow
        addRow(32'h00000001, 32'h00000001, opAdd, 32'h00000000);
        addRow(32'h00400000, 32'h00c00000, opAdd, 32'h01000000);
        addRow(32'h00400000, 32'h00400000, opAdd, 32'h00800000);
        addRow(32'h00800001, 32'h00800000, opSub, 32'h00000000);
        addRow(32'h00800000, 32'h00800001, opSub, 32'h80000000);
        addRow(32'h7f7fffff, 32'h7f7fffff, opAdd, 32'h7f800000);
        addRow(32'h7f7fffff, 32'h73000000, opAdd, 32'h7f800000);
        addRow(32'hff7fffff, 32'hff7fffff, opAdd, 32'hff800000);
    endtask

    task automatic driveOperation(input fpWord a, input fpWord b, input fpOp operation,
                                  input fpWord expected, input checkKind kind);
        pendingResult entry;
        @(posedge clk);
        inValid  <= 1'b1;
        operandA <= a;
        operandB <= b;
        op       <= operation;
        entry.expected   = expected;
        entry.kind       = kind;
        entry.issueCycle = cycleCount + 1;
        expectQ.push_back(entry);
    endtask

    function automatic fpWord finiteRandom();
        fpWord value;
        value = $random(seed);
        // Keep the exponent off the all-ones code
        if (value[30:23] == 8'hff)
            value[30] = 1'b0;
        return value;
    endfunction

    task automatic driveRandomChecks();
        fpWord a;
        fpWord b;
        fpWord nan;
        for (int i = 0; i < randomRounds; i++)
        begin
            a   = finiteRandom();
            b   = finiteRandom();
            nan = $random(seed);
            nan[30:23] = 8'hff;
            nan[0]     = 1'b1;
            driveOperation(a, b, opAdd, '0, chkPairFirst);
            driveOperation(b, a, opAdd, '0, chkPairSecond);
            driveOperation(a, a, opSub, 32'h00000000, chkExact);
            driveOperation(a, nan, opAdd, quietNaN, chkExact);
        end
    endtask

    // ####################################################################
    // Main sequence
    // ####################################################################

    initial
    begin
        seed     = 32'h7eb5;
        rst      = 1'b1;
        inValid  = 1'b0;
        operandA = '0;
        operandB = '0;
        op       = opAdd;
        for (int i = 0; i < 5; i++)
        begin
            @(posedge clk);
            if (i > 0)
            begin
                checkStrobe(outValid, 1'b0, "outValid during reset");
                checkWord(result, '0, "result during reset");
            end
        end
        rst <= 1'b0;

        loadTable();
        foreach (stimTable[i])
            driveOperation(stimTable[i].operandA, stimTable[i].operandB, stimTable[i].op,
                           stimTable[i].expected, chkExact);
        driveRandomChecks();
        @(posedge clk);
        inValid <= 1'b0;

        checkValid(drainTimeout);
        if (checkedCount == stimTable.size() + 4 * randomRounds)
        begin
            $display("No errors");
            $finish;
        end
        else
            stopOnError($sformatf("Only %0d results were checked", checkedCount));
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/fpFormatPkg.sv
rtl/fpOpsPkg.sv
rtl/fpUnpack.sv
rtl/mantissaAlign.sv
rtl/specialCase.sv
rtl/addNormalize.sv
rtl/fpAdder.sv
tb/fpAdderTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the adder testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module fpAdderTb -f compile.f -o fpAdderSim

# The log decides the outcome, so a failing run must not stop the script here
./obj_dir/fpAdderSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
